/* hw/ig_defs.svh */
`ifndef IG_DEFS_SVH
`define IG_DEFS_SVH

//////////////////////////////////////////////////
// frame geometry
//////////////////////////////////////////////////

// the frame is square, side is a power of two
`define IG_DIM_LOG2 8
`define IG_DIM      (1 << `IG_DIM_LOG2)

// raster address is {row, col}
`define IG_ADDR_W   (2 * `IG_DIM_LOG2)

//////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////

`define IG_PIX_W    8   // unsigned pixel
`define IG_FIELD_W  10  // signed difference of two pixels, one guard bit

`endif

/* hw/ig_pkg.sv */
`include "ig_defs.svh"

package ig_pkg;

    //////////////////////////////////////////////////
    // pixel and address
    //////////////////////////////////////////////////

    typedef logic [`IG_PIX_W-1:0] pixel_t;  // unsigned grey level

    // row * IG_DIM + col, so the upper half is the row
    typedef logic [`IG_ADDR_W-1:0] addr_t;

    //////////////////////////////////////////////////
    // gradient
    //////////////////////////////////////////////////

    // one signed component, range -255 .. 255
    typedef logic signed [`IG_FIELD_W-1:0] field_t;

    // gx sits in the upper half of the word
    typedef struct packed {
        field_t gx;  // right minus centre
        field_t gy;  // lower minus centre
    } grad_t;

endpackage

/* hw/frame_ram.sv */
`timescale 1ns/1ps
`include "ig_defs.svh"

// single write port, single read port, registered read
module frame_ram #(
    parameter type word_t = ig_pkg::pixel_t
) (
    input  logic          clk,
    input  logic          wr,
    input  ig_pkg::addr_t wr_addr,
    input  word_t         wr_data,
    input  ig_pkg::addr_t rd_addr,
    output word_t         rd_data
);

    localparam int DEPTH = `IG_DIM * `IG_DIM;

    word_t mem [DEPTH];

    // write lands at the clock edge
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency, old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/ig_engine.sv */
`timescale 1ns/1ps
`include "ig_defs.svh"

module ig_engine (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    output logic           busy,
    output logic           done,
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_pixel,
    output logic           grad_wr,
    output ig_pkg::addr_t  grad_addr,
    output ig_pkg::grad_t  grad_data
);

    localparam int LAST = `IG_DIM - 1;
    localparam int PAD  = `IG_FIELD_W - `IG_PIX_W;

    // read phase inside one visit
    localparam logic [1:0] PH_CEN = 2'd0;
    localparam logic [1:0] PH_RGT = 2'd1;
    localparam logic [1:0] PH_LOW = 2'd2;

    logic                    rd_active;  // issuing reads
    logic                    flush;      // trailing visit, its word is dropped
    logic [1:0]              phase;
    logic [`IG_DIM_LOG2-1:0] col;
    logic [`IG_DIM_LOG2-1:0] row;
    logic [`IG_DIM_LOG2-1:0] col_nxt;
    logic [`IG_DIM_LOG2-1:0] row_nxt;
    logic                    last_col;
    logic                    last_row;

    ig_pkg::addr_t cen_addr;
    ig_pkg::addr_t rgt_addr;
    ig_pkg::addr_t low_addr;

    logic          tag_vld;
    logic [1:0]    tag_phase;
    logic          tag_flush;
    ig_pkg::addr_t tag_addr;
    logic          low_ret;  // lower pixel is on img_pixel

    ig_pkg::pixel_t cen_q;
    ig_pkg::pixel_t rgt_q;
    ig_pkg::field_t gx;
    ig_pkg::field_t gy;

    logic          hold_vld;
    ig_pkg::grad_t hold_data;
    ig_pkg::addr_t hold_addr;

    //////////////////////////////////////////////////
    // raster position and neighbour addresses
    //////////////////////////////////////////////////

    assign col_nxt  = col + 1'b1;
    assign row_nxt  = row + 1'b1;
    assign last_col = (col == LAST[`IG_DIM_LOG2-1:0]);
    assign last_row = (row == LAST[`IG_DIM_LOG2-1:0]);

    assign cen_addr = {row, col};

    // outside the frame the centre stands in, so that field comes out zero
    assign rgt_addr = last_col ? cen_addr : {row, col_nxt};
    assign low_addr = last_row ? cen_addr : {row_nxt, col};

    always_comb begin
        case (phase)
            PH_RGT:  img_addr = rgt_addr;
            PH_LOW:  img_addr = low_addr;
            default: img_addr = cen_addr;
        endcase
    end

    assign img_rd = rd_active;

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            rd_active <= 1'b0;
            flush     <= 1'b0;
            phase     <= PH_CEN;
            col       <= '0;
            row       <= '0;
        end else if (start && !busy) begin
            busy      <= 1'b1;
            done      <= 1'b0;
            rd_active <= 1'b1;
            flush     <= 1'b0;
            phase     <= PH_CEN;
            col       <= '0;
            row       <= '0;
        end else begin
            if (rd_active) begin
                if (phase == PH_LOW) begin
                    phase <= PH_CEN;
                    col   <= col_nxt;  // wraps to 0 after the last column
                    if (last_col) begin
                        row <= row_nxt;
                    end
                    // one more visit after the last pixel pushes out its word
                    if (flush) begin
                        rd_active <= 1'b0;
                    end else if (last_col && last_row) begin
                        flush <= 1'b1;
                    end
                end else begin
                    phase <= phase + 2'd1;
                end
            end
            // run ends when the trailing visit's lower read comes back
            if (low_ret && tag_flush) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // read tags, one cycle deep
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_vld <= 1'b0;
        end else begin
            tag_vld <= img_rd;
        end
    end

    always_ff @(posedge clk) begin
        tag_phase <= phase;
        tag_flush <= flush;
        tag_addr  <= cen_addr;  // output address of this visit
    end

    assign low_ret = tag_vld && (tag_phase == PH_LOW);

    //////////////////////////////////////////////////
    // gradient datapath
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tag_vld && (tag_phase == PH_CEN)) begin
            cen_q <= img_pixel;
        end
        if (tag_vld && (tag_phase == PH_RGT)) begin
            rgt_q <= img_pixel;
        end
    end

    // zero extend to field width, then subtract as signed
    assign gx = $signed({{PAD{1'b0}}, rgt_q}) - $signed({{PAD{1'b0}}, cen_q});
    assign gy = $signed({{PAD{1'b0}}, img_pixel}) - $signed({{PAD{1'b0}}, cen_q});

    // finished word waits here until the next visit completes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
        end else if (low_ret) begin
            hold_vld <= !tag_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (low_ret) begin
            hold_data.gx <= gx;
            hold_data.gy <= gy;
            hold_addr    <= tag_addr;
        end
    end

    // the held word goes out as the next one takes its place
    assign grad_wr   = low_ret && hold_vld;
    assign grad_addr = hold_addr;
    assign grad_data = hold_data;

endmodule

/* hw/ig_top.sv */
`timescale 1ns/1ps

module ig_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    output logic           busy,
    output logic           done,
    input  logic           load_wr,
    input  ig_pkg::addr_t  load_addr,
    input  ig_pkg::pixel_t load_pixel,
    input  ig_pkg::addr_t  dump_addr,
    output ig_pkg::grad_t  dump_grad
);

    //////////////////////////////////////////////////
    // engine side wires
    //////////////////////////////////////////////////

    ig_pkg::addr_t  img_addr;
    ig_pkg::pixel_t img_pixel;
    logic           grad_wr;
    ig_pkg::addr_t  grad_addr;
    ig_pkg::grad_t  grad_data;

    //////////////////////////////////////////////////
    // image memory, host writes, engine reads
    //////////////////////////////////////////////////

    frame_ram #(
        .word_t (ig_pkg::pixel_t)
    ) u_img_ram (
        .clk     (clk),
        .wr      (load_wr),
        .wr_addr (load_addr),
        .wr_data (load_pixel),
        .rd_addr (img_addr),
        .rd_data (img_pixel)
    );

    //////////////////////////////////////////////////
    // gradient memory, engine writes, host reads
    //////////////////////////////////////////////////

    frame_ram #(
        .word_t (ig_pkg::grad_t)
    ) u_grad_ram (
        .clk     (clk),
        .wr      (grad_wr),
        .wr_addr (grad_addr),
        .wr_data (grad_data),
        .rd_addr (dump_addr),  // readable any time, one cycle later
        .rd_data (dump_grad)
    );

    //////////////////////////////////////////////////
    // engine
    //////////////////////////////////////////////////

    ig_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .img_rd    (),  // image read port always reads, the engine qualifies internally
        .img_addr  (img_addr),
        .img_pixel (img_pixel),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_data (grad_data)
    );

endmodule

/* bench/ig_chk.sv */
`timescale 1ns/1ps
`include "ig_defs.svh"

module ig_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    start,
    input logic                    busy,
    input logic                    done,
    input logic                    img_rd,
    input logic                    grad_wr,
    input ig_pkg::addr_t           grad_addr,
    input logic [1:0]              phase,
    input logic [`IG_DIM_LOG2-1:0] col,
    input logic [`IG_DIM_LOG2-1:0] row
);

    localparam logic [1:0] PH_LOW = 2'd2;

    ig_pkg::addr_t exp_addr;  // next gradient address expected

    always_ff @(posedge clk) begin
        if (!rst_n || (start && !busy)) begin
            exp_addr <= '0;
        end else if (grad_wr) begin
            exp_addr <= exp_addr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // idle and reset
    //////////////////////////////////////////////////

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !busy && !done && !img_rd && !grad_wr)
        else $error("engine active right after reset");

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !img_rd && !grad_wr)
        else $error("memory access while not busy");

    //////////////////////////////////////////////////
    // read stream, one read per busy cycle but the last
    //////////////////////////////////////////////////

    a_rd_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> img_rd)
        else $error("no read on first busy cycle");

    a_rd_inside: assert property (@(posedge clk) disable iff (!rst_n)
        img_rd |=> busy)
        else $error("busy fell right after a read");

    a_rd_last: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !img_rd |=> !busy)
        else $error("read gap inside the run");

    //////////////////////////////////////////////////
    // write stream
    //////////////////////////////////////////////////

    a_wr_gap: assert property (@(posedge clk) disable iff (!rst_n)
        grad_wr |-> !$past(grad_wr) && !$past(grad_wr, 2))
        else $error("writes closer than three cycles");

    a_wr_cadence: assert property (@(posedge clk) disable iff (!rst_n)
        $past(grad_wr, 3) && ($past(grad_addr, 3) != '1) |-> grad_wr)
        else $error("write missing three cycles after the previous one");

    a_wr_first: assert property (@(posedge clk) disable iff (!rst_n)
        busy && $past(busy, 6) && !$past(busy, 7) |-> grad_wr)
        else $error("first write not on cycle 7");

    a_wr_early: assert property (@(posedge clk) disable iff (!rst_n)
        grad_wr |-> $past(busy, 6))
        else $error("write too early in the run");

    a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        grad_wr |-> grad_addr == exp_addr)
        else $error("gradient address out of order");

    //////////////////////////////////////////////////
    // start while busy
    //////////////////////////////////////////////////

    a_start_hold: assert property (@(posedge clk) disable iff (!rst_n)
        start && busy && img_rd |=> busy && !done)
        else $error("start during a run ended it");

    a_start_step: assert property (@(posedge clk) disable iff (!rst_n)
        start && busy && (phase != PH_LOW) |=>
            (phase == $past(phase) + 2'd1) && $stable({row, col}))
        else $error("start during a run restarted the raster");

endmodule

/* bench/tb_ig.sv */
`timescale 1ns/1ps
`include "ig_defs.svh"

module tb_ig;

    localparam int NPIX            = `IG_DIM * `IG_DIM;
    localparam int LAST            = `IG_DIM - 1;
    localparam int RUN_CYCLES      = 3 * NPIX + 5;  // start edge to done, 196613
    localparam int LIMIT           = 3 * RUN_CYCLES + 3 * NPIX + 3 * (NPIX + 1) + 10000;
    localparam int EXTRA_START_CYC = 1000;          // start pulse landing mid run

    localparam int FRAME_RANDOM = 0;
    localparam int FRAME_FLAT   = 1;
    localparam int FRAME_RAMP   = 2;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           start;
    logic           busy;
    logic           done;
    logic           load_wr;
    ig_pkg::addr_t  load_addr;
    ig_pkg::pixel_t load_pixel;
    ig_pkg::addr_t  dump_addr;
    ig_pkg::grad_t  dump_grad;

    ig_pkg::pixel_t pix [NPIX];  // model copy of the image memory
    int             cycles = 0;
    bit             verdict_printed = 1'b0;

    ig_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .load_wr    (load_wr),
        .load_addr  (load_addr),
        .load_pixel (load_pixel),
        .dump_addr  (dump_addr),
        .dump_grad  (dump_grad)
    );

    bind ig_engine ig_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .img_rd    (img_rd),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .phase     (phase),
        .col       (col),
        .row       (row)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // run limit
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the test did not finish within %0d cycles", LIMIT);
            $display("Finished with errors");
            verdict_printed = 1'b1;
            $fatal(1, "simulation stopped by timeout");
        end
    end

    final begin
        if (!verdict_printed) begin
            $display("Finished with errors");
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        verdict_printed = 1'b1;
        $fatal(1, "stopped at the first error");
    endtask

    // expected word with a missing neighbour read as the centre
    function automatic ig_pkg::grad_t model_grad(input int a);
        int            row;
        int            col;
        int            cen;
        int            rgt;
        int            low;
        ig_pkg::grad_t g;
        row = a / `IG_DIM;
        col = a % `IG_DIM;
        cen = int'(pix[a]);
        rgt = (col == LAST) ? cen : int'(pix[a + 1]);
        low = (row == LAST) ? cen : int'(pix[a + `IG_DIM]);
        g.gx = ig_pkg::field_t'(rgt - cen);
        g.gy = ig_pkg::field_t'(low - cen);
        return g;
    endfunction

    task automatic load_frame(input int kind);
        int             row;
        int             col;
        ig_pkg::pixel_t p;
        for (int a = 0; a < NPIX; a++) begin
            row = a / `IG_DIM;
            col = a % `IG_DIM;
            case (kind)
                FRAME_FLAT: p = 8'd77;
                FRAME_RAMP: p = ig_pkg::pixel_t'(col + row);  // wraps past 255
                default:    p = ig_pkg::pixel_t'($urandom);
            endcase
            pix[a] = p;
            @(posedge clk);
            load_wr    <= 1'b1;
            load_addr  <= ig_pkg::addr_t'(a);
            load_pixel <= p;
        end
        @(posedge clk);
        load_wr <= 1'b0;
    endtask

    // pulse start, then follow busy cycle by cycle until done
    task automatic run_engine(input bit extra_start);
        int cyc;
        bit finished;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cyc      = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cyc++;
            if (done) begin
                assert (cyc == RUN_CYCLES)
                    else stop_on_error($sformatf("done after %0d cycles, expected %0d",
                                                 cyc, RUN_CYCLES));
                assert (!busy) else stop_on_error("busy still high while done");
                finished = 1'b1;
            end else begin
                assert (busy) else stop_on_error($sformatf("busy low at run cycle %0d", cyc));
                assert (cyc < RUN_CYCLES) else stop_on_error("done missing at end of run");
                @(posedge clk);
                start <= extra_start && (cyc == EXTRA_START_CYC);
            end
        end
    endtask

    // address goes out one cycle, word comes back the next
    task automatic dump_and_check(input int kind);
        int            a;
        int            row;
        int            col;
        ig_pkg::grad_t exp_g;
        for (int i = 0; i <= NPIX; i++) begin
            @(posedge clk);
            if (i < NPIX) begin
                dump_addr <= ig_pkg::addr_t'(i);
            end
            if (i > 0) begin
                @(negedge clk);
                a     = i - 1;
                row   = a / `IG_DIM;
                col   = a % `IG_DIM;
                exp_g = model_grad(a);
                assert (dump_grad == exp_g)
                    else stop_on_error($sformatf("word %0d is %h, model gives %h",
                                                 a, dump_grad, exp_g));
                assert (col != LAST || dump_grad.gx == 0)
                    else stop_on_error($sformatf("gx not zero on last column, word %0d", a));
                assert (row != LAST || dump_grad.gy == 0)
                    else stop_on_error($sformatf("gy not zero on last row, word %0d", a));
                if (kind == FRAME_FLAT) begin
                    assert (dump_grad == '0)
                        else stop_on_error($sformatf("flat frame word %0d not zero", a));
                end
                // interior of the ramp, before the pixel value wraps
                if (kind == FRAME_RAMP && col < LAST && row < LAST && col + row < LAST) begin
                    assert (dump_grad.gx == 1 && dump_grad.gy == 1)
                        else stop_on_error($sformatf("ramp word %0d is %h", a, dump_grad));
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main flow
    //////////////////////////////////////////////////

    initial begin
        int seed_ret;
        seed_ret   = $urandom(26343);
        rst_n      = 1'b0;
        start      = 1'b0;
        load_wr    = 1'b0;
        load_addr  = '0;
        load_pixel = '0;
        dump_addr  = '0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!busy && !done) else stop_on_error("busy or done high after reset");

        load_frame(FRAME_RANDOM);
        run_engine(1'b1);  // with one ignored start in the middle
        dump_and_check(FRAME_RANDOM);

        load_frame(FRAME_FLAT);
        run_engine(1'b0);
        dump_and_check(FRAME_FLAT);

        load_frame(FRAME_RAMP);
        run_engine(1'b0);
        dump_and_check(FRAME_RAMP);

        $display("Finished with no errors");
        verdict_printed = 1'b1;
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/ig_pkg.sv
hw/frame_ram.sv
hw/ig_engine.sv
hw/ig_top.sv
bench/ig_chk.sv
bench/tb_ig.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ig
FILELIST  := build.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh)
BIN  := obj_dir/V$(TOP)
PASS := Finished with no errors

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
